// ==== project.f ====
design/csr_pkg.sv
design/csr_access.sv
design/csr_exc_regs.sv
design/csr_int_ctrl.sv
design/csr_timer_cfg.sv
design/csr_timer.sv
design/csr_top.sv
dv/csr_tb.sv

// ==== Bender.yml ====
package:
  name: loongarch_csr

sources:
  - design/csr_pkg.sv
  - design/csr_access.sv
  - design/csr_exc_regs.sv
  - design/csr_int_ctrl.sv
  - design/csr_timer_cfg.sv
  - design/csr_timer.sv
  - design/csr_top.sv
  - target: simulation
    files:
      - dv/csr_tb.sv

// ==== dv/csr_tb.sv ====
`timescale 1ns/10ps

module csr_tb;

    logic                          clk;
    logic                          reset;
    logic                          csr_re;
    csr_pkg::csr_num_t             csr_num;
    logic                          csr_we;
    csr_pkg::csr_word_t            csr_wmask;
    csr_pkg::csr_word_t            csr_wvalue;
    logic                          wb_ex;
    csr_pkg::ecode_t               wb_ecode;
    csr_pkg::esubcode_t            wb_esubcode;
    csr_pkg::csr_word_t            wb_pc;
    csr_pkg::csr_word_t            wb_vaddr;
    logic                          ertn_flush;
    logic [csr_pkg::HW_INT_W-1:0]  hw_int_in;
    logic                          ipi_int_in;
    csr_pkg::csr_word_t            coreid_in;
    csr_pkg::csr_word_t            csr_rvalue;
    csr_pkg::csr_word_t            csr_eentry;
    logic                          has_int;

    int     errors;
    int     checks;
    integer seed;

    // reference model of the register state
    csr_pkg::csr_word_t m_crmd, m_prmd, m_ecfg, m_estat, m_era, m_badv, m_eentry;
    csr_pkg::csr_word_t m_tid, m_tcfg, m_tval;
    csr_pkg::csr_word_t m_save [4];

    csr_top csr_top_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    assert property (@(posedge clk) !csr_re |-> csr_rvalue == '0)
    else
    begin
        errors++;
        $display("[FAIL] csr_rvalue got %0h expected 0 with csr_re low", csr_rvalue);
    end

    assert property (@(posedge clk) reset |=> !has_int)
    else
    begin
        errors++;
        $display("[FAIL] has_int got %0h expected 0 after reset", has_int);
    end

    // exception entry address always mirrors EENTRY
    assert property (@(posedge clk) disable iff (reset) csr_eentry == m_eentry)
    else
    begin
        errors++;
        $display("[FAIL] csr_eentry got %0h expected %0h", csr_eentry, m_eentry);
    end

    task automatic check_word(input string name, input csr_pkg::csr_word_t got,
                              input csr_pkg::csr_word_t exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("[FAIL] %s got %0h expected %0h", name, got, exp);
        end
    endtask

    // bits reached by both masks take the new value
    function automatic csr_pkg::csr_word_t merge_expected(
        input csr_pkg::csr_word_t old_val,
        input csr_pkg::csr_word_t mask,
        input csr_pkg::csr_word_t value,
        input csr_pkg::csr_word_t regmask
    );
        return (old_val & ~(mask & regmask)) | (value & mask & regmask);
    endfunction

    function automatic csr_pkg::csr_word_t expected_read(input csr_pkg::csr_num_t num);
        case (num)
            csr_pkg::CSR_CRMD:   return m_crmd;
            csr_pkg::CSR_PRMD:   return m_prmd;
            csr_pkg::CSR_ECFG:   return m_ecfg;
            csr_pkg::CSR_ESTAT:  return m_estat;
            csr_pkg::CSR_ERA:    return m_era;
            csr_pkg::CSR_BADV:   return m_badv;
            csr_pkg::CSR_EENTRY: return m_eentry;
            csr_pkg::CSR_SAVE0:  return m_save[0];
            csr_pkg::CSR_SAVE1:  return m_save[1];
            csr_pkg::CSR_SAVE2:  return m_save[2];
            csr_pkg::CSR_SAVE3:  return m_save[3];
            csr_pkg::CSR_TID:    return m_tid;
            csr_pkg::CSR_TCFG:   return m_tcfg;
            csr_pkg::CSR_TVAL:   return m_tval;
            default:             return '0;
        endcase
    endfunction

    task automatic model_write(input csr_pkg::csr_num_t num, input csr_pkg::csr_word_t mask,
                               input csr_pkg::csr_word_t value);
        case (num)
            csr_pkg::CSR_CRMD:   m_crmd = merge_expected(m_crmd, mask, value, csr_pkg::WMASK_CRMD);
            csr_pkg::CSR_PRMD:   m_prmd = merge_expected(m_prmd, mask, value, csr_pkg::WMASK_PRMD);
            csr_pkg::CSR_ECFG:   m_ecfg = merge_expected(m_ecfg, mask, value, csr_pkg::WMASK_ECFG);
            csr_pkg::CSR_ESTAT:
                m_estat = merge_expected(m_estat, mask, value, csr_pkg::WMASK_ESTAT);
            csr_pkg::CSR_ERA:    m_era = merge_expected(m_era, mask, value, csr_pkg::WMASK_FULL);
            csr_pkg::CSR_BADV:   m_badv = merge_expected(m_badv, mask, value, csr_pkg::WMASK_FULL);
            csr_pkg::CSR_EENTRY:
                m_eentry = merge_expected(m_eentry, mask, value, csr_pkg::WMASK_EENTRY);
            csr_pkg::CSR_SAVE0:  m_save[0] = merge_expected(m_save[0], mask, value, '1);
            csr_pkg::CSR_SAVE1:  m_save[1] = merge_expected(m_save[1], mask, value, '1);
            csr_pkg::CSR_SAVE2:  m_save[2] = merge_expected(m_save[2], mask, value, '1);
            csr_pkg::CSR_SAVE3:  m_save[3] = merge_expected(m_save[3], mask, value, '1);
            csr_pkg::CSR_TID:    m_tid = merge_expected(m_tid, mask, value, csr_pkg::WMASK_FULL);
            csr_pkg::CSR_TCFG:   m_tcfg = merge_expected(m_tcfg, mask, value, csr_pkg::WMASK_TCFG);
            csr_pkg::CSR_TICLR:
                if (mask[0] && value[0])
                    m_estat[csr_pkg::TIMER_INT_BIT] = 1'b0;
            default:             ;
        endcase
    endtask

    task automatic next_drive_point();
        @(posedge clk);
        #2;
    endtask

    // all bus tasks start and end 2 ns after a rising edge
    task automatic csr_write(input csr_pkg::csr_num_t num, input csr_pkg::csr_word_t mask,
                             input csr_pkg::csr_word_t value);
        csr_we     = 1'b1;
        csr_num    = num;
        csr_wmask  = mask;
        csr_wvalue = value;
        next_drive_point();
        csr_we = 1'b0;
        model_write(num, mask, value);
    endtask

    task automatic read_csr(input csr_pkg::csr_num_t num, output csr_pkg::csr_word_t value);
        csr_re  = 1'b1;
        csr_num = num;
        @(negedge clk);
        value = csr_rvalue;
        next_drive_point();
        csr_re = 1'b0;
    endtask

    task automatic expect_csr(input csr_pkg::csr_num_t num);
        csr_pkg::csr_word_t got;
        read_csr(num, got);
        check_word($sformatf("csr_rvalue csr %0h", num), got, expected_read(num));
    endtask

    task automatic expect_has_int();
        logic exp;
        exp = ((m_estat[11:0] & m_ecfg[11:0]) != 12'h0) && m_crmd[csr_pkg::PLV_W];
        @(negedge clk);
        check_word("has_int", 32'(has_int), 32'(exp));
        next_drive_point();
    endtask

    task automatic drive_lines(input logic [csr_pkg::HW_INT_W-1:0] hw, input logic ipi);
        hw_int_in  = hw;
        ipi_int_in = ipi;
        next_drive_point();
        m_estat[csr_pkg::HW_INT_W+1:2]   = hw;
        m_estat[csr_pkg::IPI_INT_BIT]    = ipi;
    endtask

    task automatic raise_exception(input csr_pkg::ecode_t code, input csr_pkg::esubcode_t sub,
                                   input csr_pkg::csr_word_t pc, input csr_pkg::csr_word_t vaddr);
        wb_ex       = 1'b1;
        wb_ecode    = code;
        wb_esubcode = sub;
        wb_pc       = pc;
        wb_vaddr    = vaddr;
        next_drive_point();
        wb_ex = 1'b0;
        // plv and ie move to PRMD
        m_prmd[csr_pkg::PLV_W:0] = m_crmd[csr_pkg::PLV_W:0];
        m_crmd[csr_pkg::PLV_W:0] = '0;
        m_era                    = pc;
        m_estat[30:16]           = {sub, code};
        if (code == csr_pkg::ECODE_ADE && sub == '0)
            m_badv = pc;
        else if (code == csr_pkg::ECODE_ALE)
            m_badv = vaddr;
    endtask

    task automatic return_from_exception();
        ertn_flush = 1'b1;
        next_drive_point();
        ertn_flush = 1'b0;
        m_crmd[csr_pkg::PLV_W:0] = m_prmd[csr_pkg::PLV_W:0];
    endtask

    task automatic expect_exc_state();
        expect_csr(csr_pkg::CSR_CRMD);
        expect_csr(csr_pkg::CSR_PRMD);
        expect_csr(csr_pkg::CSR_ERA);
        expect_csr(csr_pkg::CSR_BADV);
        expect_csr(csr_pkg::CSR_ESTAT);
    endtask

    task automatic wait_timer_int(input int limit);
        csr_pkg::csr_word_t v;
        int n;
        v = '0;
        n = 0;
        while (!v[csr_pkg::TIMER_INT_BIT] && n < limit)
        begin
            read_csr(csr_pkg::CSR_ESTAT, v);
            n++;
        end
        if (v[csr_pkg::TIMER_INT_BIT])
            m_estat[csr_pkg::TIMER_INT_BIT] = 1'b1;
        else
        begin
            errors++;
            $display("timer interrupt never showed in ESTAT within %0d cycles", limit);
        end
    endtask

    task automatic wait_tval_zero(input int limit);
        csr_pkg::csr_word_t v;
        int n;
        v = '1;
        n = 0;
        while (v != '0 && n < limit)
        begin
            read_csr(csr_pkg::CSR_TVAL, v);
            n++;
        end
        if (v != '0)
        begin
            errors++;
            $display("timer counter never reached zero within %0d cycles", limit);
        end
    endtask

    initial
    begin
        csr_pkg::csr_num_t  wr_nums [15];
        csr_pkg::csr_word_t mask;
        csr_pkg::csr_word_t value;
        csr_pkg::csr_word_t got;

        errors      = 0;
        checks      = 0;
        seed        = 2;
        reset       = 1'b1;
        csr_re      = 1'b0;
        csr_num     = '0;
        csr_we      = 1'b0;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        wb_ex       = 1'b0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        wb_pc       = '0;
        wb_vaddr    = '0;
        ertn_flush  = 1'b0;
        hw_int_in   = '0;
        ipi_int_in  = 1'b0;
        coreid_in   = 32'h0000_0005;

        wr_nums = '{csr_pkg::CSR_CRMD, csr_pkg::CSR_PRMD, csr_pkg::CSR_ECFG, csr_pkg::CSR_ESTAT,
                    csr_pkg::CSR_ERA, csr_pkg::CSR_BADV, csr_pkg::CSR_EENTRY,
                    csr_pkg::CSR_SAVE0, csr_pkg::CSR_SAVE1, csr_pkg::CSR_SAVE2,
                    csr_pkg::CSR_SAVE3, csr_pkg::CSR_TID, csr_pkg::CSR_TCFG,
                    csr_pkg::CSR_TVAL, csr_pkg::CSR_TICLR};
        m_crmd   = csr_pkg::CRMD_RESET;
        m_prmd   = '0;
        m_ecfg   = '0;
        m_estat  = '0;
        m_era    = '0;
        m_badv   = '0;
        m_eentry = '0;
        m_save   = '{default: '0};
        m_tid    = coreid_in;
        m_tcfg   = '0;
        m_tval   = csr_pkg::TIMER_IDLE;

        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;

        expect_csr(csr_pkg::CSR_CRMD);
        expect_csr(csr_pkg::CSR_ECFG);
        expect_csr(csr_pkg::CSR_ESTAT);
        expect_csr(csr_pkg::CSR_TCFG);
        expect_csr(csr_pkg::CSR_TVAL);
        expect_csr(csr_pkg::CSR_TID);
        expect_has_int();

        // every writable register four times with TVAL and TICLR in passing
        for (int round = 0; round < 4; round++)
        begin
            for (int j = 0; j < 15; j++)
            begin
                mask  = $random(seed);
                value = $random(seed);
                // timer stays stopped
                if (wr_nums[j] == csr_pkg::CSR_TCFG)
                    value[0] = 1'b0;
                csr_write(wr_nums[j], mask, value);
                expect_csr(wr_nums[j]);
            end
        end
        expect_csr(csr_pkg::CSR_TICLR);
        expect_csr(14'h3ff);
        csr_num = csr_pkg::CSR_SAVE0;
        @(negedge clk);
        check_word("csr_rvalue with csr_re low", csr_rvalue, '0);
        next_drive_point();

        // plv 3 with ie set
        csr_write(csr_pkg::CSR_CRMD, 32'h7, 32'h7);
        raise_exception(csr_pkg::ECODE_ALE, '0, 32'h1c00_0104, 32'h0000_2003);
        expect_exc_state();
        return_from_exception();
        expect_csr(csr_pkg::CSR_CRMD);
        raise_exception(csr_pkg::ECODE_ADE, '0, 32'h1c00_0202, 32'h0000_5555);
        expect_exc_state();
        return_from_exception();
        expect_csr(csr_pkg::CSR_CRMD);

        csr_write(csr_pkg::CSR_ECFG, '1, '0);
        csr_write(csr_pkg::CSR_ESTAT, '1, '0);
        csr_write(csr_pkg::CSR_CRMD, 32'h4, 32'h4);
        drive_lines(8'h10, 1'b0);
        expect_has_int();
        csr_write(csr_pkg::CSR_ECFG, 32'h40, 32'h40);
        expect_has_int();
        csr_write(csr_pkg::CSR_CRMD, 32'h4, 32'h0);
        expect_has_int();
        csr_write(csr_pkg::CSR_CRMD, 32'h4, 32'h4);
        expect_has_int();
        // ipi alone stays out of has_int even when enabled
        drive_lines(8'h00, 1'b1);
        csr_write(csr_pkg::CSR_ECFG, 32'h1000, 32'h1000);
        expect_has_int();
        csr_write(csr_pkg::CSR_ECFG, 32'h3, 32'h2);
        csr_write(csr_pkg::CSR_ESTAT, 32'h3, 32'h2);
        expect_has_int();
        csr_write(csr_pkg::CSR_ESTAT, 32'h3, 32'h0);
        expect_has_int();
        drive_lines(8'h00, 1'b0);
        expect_csr(csr_pkg::CSR_ESTAT);

        // one-shot timer with initval 5
        csr_write(csr_pkg::CSR_TCFG, '1, 32'h0000_0015);
        read_csr(csr_pkg::CSR_TVAL, got);
        check_word("csr_rvalue TVAL after load", got, 32'd20);
        read_csr(csr_pkg::CSR_TVAL, got);
        check_word("csr_rvalue TVAL counting", got, 32'd19);
        wait_timer_int(100);
        expect_csr(csr_pkg::CSR_TVAL);
        csr_write(csr_pkg::CSR_TICLR, 32'h1, 32'h1);
        expect_csr(csr_pkg::CSR_ESTAT);
        repeat (3) expect_csr(csr_pkg::CSR_TVAL);

        // periodic timer with initval 3
        csr_write(csr_pkg::CSR_TCFG, '1, 32'h0000_000f);
        read_csr(csr_pkg::CSR_TVAL, got);
        check_word("csr_rvalue TVAL after load", got, 32'd12);
        wait_tval_zero(100);
        read_csr(csr_pkg::CSR_TVAL, got);
        check_word("csr_rvalue TVAL after reload", got, 32'd12);
        m_estat[csr_pkg::TIMER_INT_BIT] = 1'b1;
        csr_write(csr_pkg::CSR_TICLR, 32'h1, 32'h1);
        expect_csr(csr_pkg::CSR_ESTAT);
        wait_timer_int(100);
        csr_write(csr_pkg::CSR_TCFG, '1, '0);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== design/csr_top.sv ====
`timescale 1ns/10ps

module csr_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          csr_re,
    input  csr_pkg::csr_num_t             csr_num,
    input  logic                          csr_we,
    input  csr_pkg::csr_word_t            csr_wmask,
    input  csr_pkg::csr_word_t            csr_wvalue,
    input  logic                          wb_ex,
    input  csr_pkg::ecode_t               wb_ecode,
    input  csr_pkg::esubcode_t            wb_esubcode,
    input  csr_pkg::csr_word_t            wb_pc,
    input  csr_pkg::csr_word_t            wb_vaddr,
    input  logic                          ertn_flush,
    input  logic [csr_pkg::HW_INT_W-1:0]  hw_int_in,
    input  logic                          ipi_int_in,
    input  csr_pkg::csr_word_t            coreid_in,
    output csr_pkg::csr_word_t            csr_rvalue,
    output csr_pkg::csr_word_t            csr_eentry,
    output logic                          has_int
);

    csr_pkg::csr_word_t crmd_word, prmd_word, ecfg_word, estat_word, era_word, badv_word;
    csr_pkg::csr_word_t eentry_word, save0_word, save1_word, save2_word, save3_word;
    csr_pkg::csr_word_t tid_word, tcfg_word, tval_word, estat_code_word, load_value;
    logic               crmd_wr, prmd_wr, ecfg_wr, estat_wr, era_wr, badv_wr, eentry_wr;
    logic               tid_wr, tcfg_wr, ticlr_clear, crmd_ie;
    logic [3:0]         save_wr;
    logic               tcfg_en, tcfg_periodic, timer_load, timer_zero;
    logic [csr_pkg::TCFG_INITVAL_W-1:0] tcfg_initval;

    csr_access csr_access_i (
        .csr_re, .csr_num, .csr_we, .csr_wmask, .csr_wvalue,
        .crmd_word, .prmd_word, .ecfg_word, .estat_word, .era_word, .badv_word,
        .eentry_word, .save0_word, .save1_word, .save2_word, .save3_word,
        .tid_word, .tcfg_word, .tval_word,
        .crmd_wr, .prmd_wr, .ecfg_wr, .estat_wr, .era_wr, .badv_wr, .eentry_wr,
        .save_wr, .tid_wr, .tcfg_wr, .ticlr_clear, .csr_rvalue
    );

    csr_exc_regs csr_exc_regs_i (
        .clk, .reset, .crmd_wr, .prmd_wr, .era_wr, .badv_wr, .eentry_wr, .estat_wr,
        .save_wr, .csr_wmask, .csr_wvalue, .wb_ex, .wb_ecode, .wb_esubcode, .wb_pc,
        .wb_vaddr, .ertn_flush,
        .crmd_word, .prmd_word, .era_word, .badv_word, .eentry_word,
        .save0_word, .save1_word, .save2_word, .save3_word,
        .estat_code_word, .crmd_ie, .csr_eentry
    );

    csr_int_ctrl csr_int_ctrl_i (
        .clk, .reset, .ecfg_wr, .estat_wr, .csr_wmask, .csr_wvalue, .hw_int_in,
        .ipi_int_in, .timer_zero, .ticlr_clear, .crmd_ie, .estat_code_word,
        .ecfg_word, .estat_word, .has_int
    );

    csr_timer_cfg csr_timer_cfg_i (
        .clk, .reset, .tid_wr, .tcfg_wr, .csr_wmask, .csr_wvalue, .coreid_in,
        .tid_word, .tcfg_word, .tcfg_en, .tcfg_periodic, .tcfg_initval,
        .timer_load, .load_value
    );

    csr_timer csr_timer_i (
        .clk, .reset, .tcfg_en, .tcfg_periodic, .tcfg_initval, .timer_load,
        .load_value, .tval_word, .timer_zero
    );

endmodule

// ==== design/csr_timer.sv ====
`timescale 1ns/10ps

module csr_timer (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                tcfg_en,
    input  logic                                tcfg_periodic,
    input  logic [csr_pkg::TCFG_INITVAL_W-1:0]  tcfg_initval,
    input  logic                                timer_load,
    input  csr_pkg::csr_word_t                  load_value,
    output csr_pkg::csr_word_t                  tval_word,
    output logic                                timer_zero
);

    csr_pkg::csr_word_t timer_cnt;

    always_ff @(posedge clk)
    begin
        if (reset)
            timer_cnt <= csr_pkg::TIMER_IDLE;
        else if (timer_load)
            timer_cnt <= load_value;
        else if (tcfg_en && timer_cnt != csr_pkg::TIMER_IDLE)
        begin
            // one-shot falls through zero to idle and parks there
            if (timer_zero && tcfg_periodic)
                timer_cnt <= {tcfg_initval, 2'b00};
            else
                timer_cnt <= timer_cnt - 32'd1;
        end
    end

    assign timer_zero = (timer_cnt == '0);
    assign tval_word  = timer_cnt;

    assert property (@(posedge clk) disable iff (reset)
                     !tcfg_en && !timer_load && timer_cnt == csr_pkg::TIMER_IDLE
                     |=> timer_cnt == csr_pkg::TIMER_IDLE);

endmodule

// ==== design/csr_timer_cfg.sv ====
`timescale 1ns/10ps

module csr_timer_cfg (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                tid_wr,
    input  logic                                tcfg_wr,
    input  csr_pkg::csr_word_t                  csr_wmask,
    input  csr_pkg::csr_word_t                  csr_wvalue,
    input  csr_pkg::csr_word_t                  coreid_in,
    output csr_pkg::csr_word_t                  tid_word,
    output csr_pkg::csr_word_t                  tcfg_word,
    output logic                                tcfg_en,
    output logic                                tcfg_periodic,
    output logic [csr_pkg::TCFG_INITVAL_W-1:0]  tcfg_initval,
    output logic                                timer_load,
    output csr_pkg::csr_word_t                  load_value
);

    csr_pkg::csr_word_t tid_q;
    csr_pkg::csr_word_t tcfg_q;
    csr_pkg::csr_word_t tcfg_next;

    assign tcfg_next = csr_pkg::wmerge(tcfg_q, csr_wmask, csr_wvalue, csr_pkg::WMASK_TCFG);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tid_q  <= coreid_in;
            tcfg_q <= '0;
        end
        else
        begin
            if (tid_wr)
                tid_q <= csr_pkg::wmerge(tid_q, csr_wmask, csr_wvalue, csr_pkg::WMASK_FULL);
            if (tcfg_wr)
                tcfg_q <= tcfg_next;
        end
    end

    assign tid_word      = tid_q;
    assign tcfg_word     = tcfg_q;
    assign tcfg_en       = tcfg_q[0];
    assign tcfg_periodic = tcfg_q[1];
    assign tcfg_initval  = tcfg_q[31:2];

    // start from the merged word, not the stored one
    assign timer_load = tcfg_wr && tcfg_next[0];
    assign load_value = {tcfg_next[31:2], 2'b00};

endmodule

// ==== design/csr_int_ctrl.sv ====
`timescale 1ns/10ps

module csr_int_ctrl (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          ecfg_wr,
    input  logic                          estat_wr,
    input  csr_pkg::csr_word_t            csr_wmask,
    input  csr_pkg::csr_word_t            csr_wvalue,
    input  logic [csr_pkg::HW_INT_W-1:0]  hw_int_in,
    input  logic                          ipi_int_in,
    input  logic                          timer_zero,
    input  logic                          ticlr_clear,
    input  logic                          crmd_ie,
    input  csr_pkg::csr_word_t            estat_code_word,
    output csr_pkg::csr_word_t            ecfg_word,
    output csr_pkg::csr_word_t            estat_word,
    output logic                          has_int
);

    localparam int INT_W = csr_pkg::INT_W;

    csr_pkg::csr_word_t  ecfg_next;
    csr_pkg::csr_word_t  estat_next;
    logic [INT_W-1:0]    ecfg_lie;
    logic [INT_W-1:0]    estat_is;

    assign ecfg_next  = csr_pkg::wmerge(ecfg_word, csr_wmask, csr_wvalue, csr_pkg::WMASK_ECFG);
    assign estat_next = csr_pkg::wmerge(estat_word, csr_wmask, csr_wvalue,
                                        csr_pkg::WMASK_ESTAT);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ecfg_lie <= '0;
            estat_is <= '0;
        end
        else
        begin
            if (ecfg_wr)
                ecfg_lie <= ecfg_next[INT_W-1:0];
            if (estat_wr)
                estat_is[1:0] <= estat_next[1:0];
            estat_is[csr_pkg::HW_INT_W+1:2] <= hw_int_in;
            estat_is[10]                     <= 1'b0;
            // set wins over clear
            if (timer_zero)
                estat_is[csr_pkg::TIMER_INT_BIT] <= 1'b1;
            else if (ticlr_clear)
                estat_is[csr_pkg::TIMER_INT_BIT] <= 1'b0;
            estat_is[csr_pkg::IPI_INT_BIT] <= ipi_int_in;
        end
    end

    assign ecfg_word  = {{(32-INT_W){1'b0}}, ecfg_lie};
    assign estat_word = estat_code_word | {{(32-INT_W){1'b0}}, estat_is};

    // ipi line is kept out of the decision
    assign has_int = ((estat_is[11:0] & ecfg_lie[11:0]) != 12'b0) && crmd_ie;

    assert property (@(posedge clk) disable iff (reset) estat_word[10] == 1'b0);

endmodule

// ==== design/csr_exc_regs.sv ====
`timescale 1ns/10ps

module csr_exc_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 crmd_wr,
    input  logic                 prmd_wr,
    input  logic                 era_wr,
    input  logic                 badv_wr,
    input  logic                 eentry_wr,
    input  logic                 estat_wr,
    input  logic [3:0]           save_wr,
    input  csr_pkg::csr_word_t   csr_wmask,
    input  csr_pkg::csr_word_t   csr_wvalue,
    input  logic                 wb_ex,
    input  csr_pkg::ecode_t      wb_ecode,
    input  csr_pkg::esubcode_t   wb_esubcode,
    input  csr_pkg::csr_word_t   wb_pc,
    input  csr_pkg::csr_word_t   wb_vaddr,
    input  logic                 ertn_flush,
    output csr_pkg::csr_word_t   crmd_word,
    output csr_pkg::csr_word_t   prmd_word,
    output csr_pkg::csr_word_t   era_word,
    output csr_pkg::csr_word_t   badv_word,
    output csr_pkg::csr_word_t   eentry_word,
    output csr_pkg::csr_word_t   save0_word,
    output csr_pkg::csr_word_t   save1_word,
    output csr_pkg::csr_word_t   save2_word,
    output csr_pkg::csr_word_t   save3_word,
    output csr_pkg::csr_word_t   estat_code_word,
    output logic                 crmd_ie,
    output csr_pkg::csr_word_t   csr_eentry
);

    localparam int PIE_BIT = csr_pkg::PLV_W;

    csr_pkg::csr_word_t             crmd_q;
    csr_pkg::csr_word_t             prmd_q;
    csr_pkg::csr_word_t             era_q;
    csr_pkg::csr_word_t             badv_q;
    csr_pkg::csr_word_t             save_q [4];
    csr_pkg::csr_word_t             eentry_next;
    logic [csr_pkg::EENTRY_VA_W-1:0] eentry_va;
    csr_pkg::ecode_t                estat_ecode;
    csr_pkg::esubcode_t             estat_esubcode;
    logic                           is_adef;
    logic                           is_ale;

    assign is_adef = (wb_ecode == csr_pkg::ECODE_ADE) && (wb_esubcode == '0);
    assign is_ale  = (wb_ecode == csr_pkg::ECODE_ALE);

    // plv and ie sit in the low bits of both CRMD and PRMD
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            crmd_q <= csr_pkg::CRMD_RESET;
            prmd_q <= '0;
        end
        else if (wb_ex)
        begin
            crmd_q[PIE_BIT:0] <= '0;
            prmd_q[PIE_BIT:0] <= crmd_q[PIE_BIT:0];
        end
        else if (ertn_flush)
            crmd_q[PIE_BIT:0] <= prmd_q[PIE_BIT:0];
        else if (crmd_wr)
            crmd_q <= csr_pkg::wmerge(crmd_q, csr_wmask, csr_wvalue, csr_pkg::WMASK_CRMD);
        else if (prmd_wr)
            prmd_q <= csr_pkg::wmerge(prmd_q, csr_wmask, csr_wvalue, csr_pkg::WMASK_PRMD);
    end

    assign eentry_next = csr_pkg::wmerge(eentry_word, csr_wmask, csr_wvalue,
                                         csr_pkg::WMASK_EENTRY);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            era_q          <= '0;
            badv_q         <= '0;
            eentry_va      <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            save_q         <= '{default: '0};
        end
        else
        begin
            if (wb_ex)
            begin
                era_q          <= wb_pc;
                estat_ecode    <= wb_ecode;
                estat_esubcode <= wb_esubcode;
            end
            else if (era_wr)
                era_q <= csr_pkg::wmerge(era_q, csr_wmask, csr_wvalue, csr_pkg::WMASK_FULL);

            // fetch faults record the pc and alignment faults the data address
            if (wb_ex && is_adef)
                badv_q <= wb_pc;
            else if (wb_ex && is_ale)
                badv_q <= wb_vaddr;
            else if (badv_wr)
                badv_q <= csr_pkg::wmerge(badv_q, csr_wmask, csr_wvalue, csr_pkg::WMASK_FULL);

            if (eentry_wr)
                eentry_va <= eentry_next[31:32-csr_pkg::EENTRY_VA_W];

            for (int i = 0; i < 4; i++)
            begin
                if (save_wr[i])
                    save_q[i] <= csr_pkg::wmerge(save_q[i], csr_wmask, csr_wvalue,
                                                 csr_pkg::WMASK_FULL);
            end
        end
    end

    assign crmd_word       = crmd_q;
    assign prmd_word       = prmd_q;
    assign era_word        = era_q;
    assign badv_word       = badv_q;
    assign eentry_word     = {eentry_va, {(32-csr_pkg::EENTRY_VA_W){1'b0}}};
    assign csr_eentry      = eentry_word;
    assign save0_word      = save_q[0];
    assign save1_word      = save_q[1];
    assign save2_word      = save_q[2];
    assign save3_word      = save_q[3];
    assign estat_code_word = {1'b0, estat_esubcode, estat_ecode, 16'b0};
    assign crmd_ie         = crmd_q[PIE_BIT];

    assert property (@(posedge clk) disable iff (reset) !(wb_ex && ertn_flush));

endmodule

// ==== design/csr_access.sv ====
`timescale 1ns/10ps

module csr_access (
    input  logic                csr_re,
    input  csr_pkg::csr_num_t   csr_num,
    input  logic                csr_we,
    input  csr_pkg::csr_word_t  csr_wmask,
    input  csr_pkg::csr_word_t  csr_wvalue,
    input  csr_pkg::csr_word_t  crmd_word,
    input  csr_pkg::csr_word_t  prmd_word,
    input  csr_pkg::csr_word_t  ecfg_word,
    input  csr_pkg::csr_word_t  estat_word,
    input  csr_pkg::csr_word_t  era_word,
    input  csr_pkg::csr_word_t  badv_word,
    input  csr_pkg::csr_word_t  eentry_word,
    input  csr_pkg::csr_word_t  save0_word,
    input  csr_pkg::csr_word_t  save1_word,
    input  csr_pkg::csr_word_t  save2_word,
    input  csr_pkg::csr_word_t  save3_word,
    input  csr_pkg::csr_word_t  tid_word,
    input  csr_pkg::csr_word_t  tcfg_word,
    input  csr_pkg::csr_word_t  tval_word,
    output logic                crmd_wr,
    output logic                prmd_wr,
    output logic                ecfg_wr,
    output logic                estat_wr,
    output logic                era_wr,
    output logic                badv_wr,
    output logic                eentry_wr,
    output logic [3:0]          save_wr,
    output logic                tid_wr,
    output logic                tcfg_wr,
    output logic                ticlr_clear,
    output csr_pkg::csr_word_t  csr_rvalue
);

    csr_pkg::csr_word_t rdata;

    assign crmd_wr    = csr_we && (csr_num == csr_pkg::CSR_CRMD);
    assign prmd_wr    = csr_we && (csr_num == csr_pkg::CSR_PRMD);
    assign ecfg_wr    = csr_we && (csr_num == csr_pkg::CSR_ECFG);
    assign estat_wr   = csr_we && (csr_num == csr_pkg::CSR_ESTAT);
    assign era_wr     = csr_we && (csr_num == csr_pkg::CSR_ERA);
    assign badv_wr    = csr_we && (csr_num == csr_pkg::CSR_BADV);
    assign eentry_wr  = csr_we && (csr_num == csr_pkg::CSR_EENTRY);
    assign save_wr[0] = csr_we && (csr_num == csr_pkg::CSR_SAVE0);
    assign save_wr[1] = csr_we && (csr_num == csr_pkg::CSR_SAVE1);
    assign save_wr[2] = csr_we && (csr_num == csr_pkg::CSR_SAVE2);
    assign save_wr[3] = csr_we && (csr_num == csr_pkg::CSR_SAVE3);
    assign tid_wr     = csr_we && (csr_num == csr_pkg::CSR_TID);
    assign tcfg_wr    = csr_we && (csr_num == csr_pkg::CSR_TCFG);

    // TICLR only acts on a write-1 to bit 0
    assign ticlr_clear = csr_we && (csr_num == csr_pkg::CSR_TICLR)
                         && csr_wmask[0] && csr_wvalue[0];

    always_comb
    begin
        case (csr_num)
            csr_pkg::CSR_CRMD:   rdata = crmd_word;
            csr_pkg::CSR_PRMD:   rdata = prmd_word;
            csr_pkg::CSR_ECFG:   rdata = ecfg_word;
            csr_pkg::CSR_ESTAT:  rdata = estat_word;
            csr_pkg::CSR_ERA:    rdata = era_word;
            csr_pkg::CSR_BADV:   rdata = badv_word;
            csr_pkg::CSR_EENTRY: rdata = eentry_word;
            csr_pkg::CSR_SAVE0:  rdata = save0_word;
            csr_pkg::CSR_SAVE1:  rdata = save1_word;
            csr_pkg::CSR_SAVE2:  rdata = save2_word;
            csr_pkg::CSR_SAVE3:  rdata = save3_word;
            csr_pkg::CSR_TID:    rdata = tid_word;
            csr_pkg::CSR_TCFG:   rdata = tcfg_word;
            csr_pkg::CSR_TVAL:   rdata = tval_word;
            default:             rdata = '0;
        endcase
    end

    assign csr_rvalue = csr_re ? rdata : '0;

    always_comb
    begin
        assert final ($onehot0({crmd_wr, prmd_wr, ecfg_wr, estat_wr, era_wr, badv_wr,
                                eentry_wr, save_wr, tid_wr, tcfg_wr, ticlr_clear}));
    end

endmodule

// ==== design/csr_pkg.sv ====
package csr_pkg;

    typedef logic [13:0] csr_num_t;
    typedef logic [31:0] csr_word_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;

    // csr numbers
    localparam csr_num_t CSR_CRMD   = 14'h000;
    localparam csr_num_t CSR_PRMD   = 14'h001;
    localparam csr_num_t CSR_ECFG   = 14'h004;
    localparam csr_num_t CSR_ESTAT  = 14'h005;
    localparam csr_num_t CSR_ERA    = 14'h006;
    localparam csr_num_t CSR_BADV   = 14'h007;
    localparam csr_num_t CSR_EENTRY = 14'h00c;
    localparam csr_num_t CSR_SAVE0  = 14'h030;
    localparam csr_num_t CSR_SAVE1  = 14'h031;
    localparam csr_num_t CSR_SAVE2  = 14'h032;
    localparam csr_num_t CSR_SAVE3  = 14'h033;
    localparam csr_num_t CSR_TID    = 14'h040;
    localparam csr_num_t CSR_TCFG   = 14'h041;
    localparam csr_num_t CSR_TVAL   = 14'h042;
    localparam csr_num_t CSR_TICLR  = 14'h044;

    // ADE with esubcode 0 is ADEF
    localparam ecode_t ECODE_ADE = 6'h08;
    localparam ecode_t ECODE_ALE = 6'h09;

    localparam int PLV_W          = 2;
    localparam int INT_W          = 13;
    localparam int HW_INT_W       = 8;
    localparam int EENTRY_VA_W    = 26;
    localparam int TCFG_INITVAL_W = 30;

    localparam int TIMER_INT_BIT = 11;
    localparam int IPI_INT_BIT   = 12;

    // software writable bits
    localparam csr_word_t WMASK_CRMD   = 32'h0000_01ff;
    localparam csr_word_t WMASK_PRMD   = 32'h0000_0007;
    localparam csr_word_t WMASK_ECFG   = 32'h0000_1fff;
    localparam csr_word_t WMASK_ESTAT  = 32'h0000_0003;
    localparam csr_word_t WMASK_EENTRY = 32'hffff_ffc0;
    localparam csr_word_t WMASK_TCFG   = 32'hffff_ffff;
    localparam csr_word_t WMASK_FULL   = 32'hffff_ffff;

    localparam csr_word_t TIMER_IDLE = 32'hffff_ffff;
    localparam csr_word_t CRMD_RESET = 32'h0000_0008;

    // bits reached by both the write mask and the register mask take the new value
    function automatic csr_word_t wmerge(
        input csr_word_t old_val,
        input csr_word_t wmask,
        input csr_word_t wvalue,
        input csr_word_t regmask
    );
        csr_word_t m;
        m = wmask & regmask;
        return (old_val & ~m) | (wvalue & m);
    endfunction

endpackage
